// ==== avl_bus_pkg.sv ====
//////////////////////////////////////////////////
// bus widths and vector types for the traffic generator, the
// command FIFO and the memory model, also imported by the testbench
//////////////////////////////////////////////////
package avl_bus_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////

   // word address width, so the memory model holds 2**ADDR_W words
   localparam int ADDR_W = 6;

   // data width of one beat, also the width of pnf and the fault mask
   localparam int DATA_W = 32;

   // cycles from the pop edge of a read until its data is valid at the memory port
   localparam int MEM_READ_LATENCY = 2;

   //////////////////////////////////////////////////
   // vector types
   //////////////////////////////////////////////////

   // word address, no byte offset since every access is a full word
   typedef logic [ADDR_W-1:0] addr_t;

   // one data beat
   typedef logic [DATA_W-1:0] data_t;

   // words read counter, one bit wider so a full address range still fits
   typedef logic [ADDR_W:0] count_t;

endpackage

// ==== tg_cfg_pkg.sv ====
//////////////////////////////////////////////////
// traffic test configuration, the command buffer depth
// and the state encoding of the traffic generator FSM
//////////////////////////////////////////////////
package tg_cfg_pkg;

   // words written and read back, from address 0 upward
   localparam int NUM_TEST_WORDS = 16;

   // entries in the command FIFO between driver and memory
   localparam int FIFO_DEPTH = 4;

   // FIFO pointer width and count width (the count must reach FIFO_DEPTH itself)
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

   // driver FSM states
   typedef enum logic [2:0] {
      INIT,
      ISSUE_WRITE,
      WAIT_WRITE_DONE,
      ISSUE_READ,
      WAIT_READ_ACCEPTED,
      WAIT_READ_DONE,
      DONE_PASS,
      DONE_FAIL
   } tg_state_t;

endpackage

// ==== tg_driver.sv ====
//////////////////////////////////////////////////
// traffic generator for memory bring-up: writes the test region with
// data equal to the word index, reads it back one word at a time and
// checks every beat, ending in a sticky pass or fail state
//////////////////////////////////////////////////
module tg_driver (
   input  logic                clk,
   input  logic                reset_n,

   // command side, toward the command FIFO
   input  logic                ready,
   output logic                write_req,
   output logic                read_req,
   output avl_bus_pkg::addr_t  addr,
   output avl_bus_pkg::data_t  wdata,

   // read data return from the memory
   input  logic                rdata_valid,
   input  avl_bus_pkg::data_t  rdata,

   // status
   output logic                pass,
   output logic                fail,
   output avl_bus_pkg::data_t  pnf,
   output avl_bus_pkg::count_t words_read
);
   import avl_bus_pkg::*;
   import tg_cfg_pkg::*;

   // last word address of the test region
   localparam addr_t LAST_WORD_ADDR = addr_t'(NUM_TEST_WORDS - 1);

   // read return registered once before the compare
   logic       rdata_valid_r;
   data_t      rdata_r;

   tg_state_t  state;
   tg_state_t  nxt_state;

   logic       nxt_write_req;
   logic       nxt_read_req;
   addr_t      word_addr;
   addr_t      nxt_word_addr;
   data_t      golden_data;
   data_t      nxt_golden_data;
   data_t      nxt_pnf;
   count_t     nxt_words_read;

   //////////////////////////////////////////////////
   // control and status registers
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state         <= INIT;
         write_req     <= 1'b0;
         read_req      <= 1'b0;
         rdata_valid_r <= 1'b0;
         pnf           <= '1;
         words_read    <= '0;
      end else begin
         state         <= nxt_state;
         write_req     <= nxt_write_req;
         read_req      <= nxt_read_req;
         rdata_valid_r <= rdata_valid;
         pnf           <= nxt_pnf;
         words_read    <= nxt_words_read;
      end
   end

   // payload registers, only meaningful once the FSM has left INIT
   always_ff @(posedge clk) begin
      wdata       <= golden_data;
      rdata_r     <= rdata;
      word_addr   <= nxt_word_addr;
      golden_data <= nxt_golden_data;
   end

   // the address is steady while a request is held, since word_addr only
   // moves after the command has been taken
   assign addr = word_addr;

   //////////////////////////////////////////////////
   // status
   //////////////////////////////////////////////////
   assign pass = (state == DONE_PASS);
   assign fail = (state == DONE_FAIL);

   //////////////////////////////////////////////////
   // next-state logic
   //////////////////////////////////////////////////
   always_comb begin
      // hold everything by default, requests drop unless a state asks for them
      nxt_state       = state;
      nxt_write_req   = 1'b0;
      nxt_read_req    = 1'b0;
      nxt_word_addr   = word_addr;
      nxt_golden_data = golden_data;
      nxt_pnf         = pnf;
      nxt_words_read  = words_read;

      case (state)
         INIT: begin
            // start at word 0, golden data tracks the word index
            nxt_state       = ISSUE_WRITE;
            nxt_word_addr   = '0;
            nxt_golden_data = '0;
         end

         ISSUE_WRITE: begin
            // wdata picks up golden_data on this edge, together with the request
            nxt_state     = WAIT_WRITE_DONE;
            nxt_write_req = 1'b1;
         end

         WAIT_WRITE_DONE: begin
            if (!ready) begin
               // FIFO full, keep the request and fields steady
               nxt_write_req = 1'b1;
            end else if (word_addr != LAST_WORD_ADDR) begin
               // write taken on this edge, move to the next word
               nxt_state       = ISSUE_WRITE;
               nxt_word_addr   = word_addr + addr_t'(1);
               nxt_golden_data = golden_data + data_t'(1);
            end else begin
               // last write taken, go back to word 0 for the read pass
               nxt_state       = ISSUE_READ;
               nxt_word_addr   = '0;
               nxt_golden_data = '0;
            end
         end

         ISSUE_READ: begin
            nxt_state    = WAIT_READ_ACCEPTED;
            nxt_read_req = 1'b1;
         end

         WAIT_READ_ACCEPTED: begin
            if (!ready) begin
               nxt_read_req = 1'b1;
            end else begin
               // command accepted, data comes back after a variable delay
               nxt_state = WAIT_READ_DONE;
            end
         end

         WAIT_READ_DONE: begin
            if (rdata_valid_r) begin
               // every returned beat counts, the failing one too
               nxt_words_read = words_read + count_t'(1);

               if (rdata_r != golden_data) begin
                  // mark the bad bits with zeros and stop
                  nxt_state = DONE_FAIL;
                  nxt_pnf   = ~(rdata_r ^ golden_data);
               end else if (word_addr != LAST_WORD_ADDR) begin
                  nxt_state       = ISSUE_READ;
                  nxt_word_addr   = word_addr + addr_t'(1);
                  nxt_golden_data = golden_data + data_t'(1);
               end else begin
                  nxt_state = DONE_PASS;
               end
            end
         end

         // both end states hold until reset
         DONE_PASS: nxt_state = DONE_PASS;
         DONE_FAIL: nxt_state = DONE_FAIL;

         default: nxt_state = INIT;
      endcase
   end

endmodule

// ==== cmd_fifo.sv ====
//////////////////////////////////////////////////
// command FIFO between the traffic generator and the memory model,
// ready is high while there is room for one more command
//////////////////////////////////////////////////
module cmd_fifo (
   input  logic               clk,
   input  logic               reset_n,

   // push side, from the driver
   input  logic               write_req,
   input  logic               read_req,
   input  avl_bus_pkg::addr_t addr,
   input  avl_bus_pkg::data_t wdata,
   output logic               ready,

   // pop side, head entry toward the memory
   output logic               cmd_valid,
   output logic               cmd_write,
   output avl_bus_pkg::addr_t cmd_addr,
   output avl_bus_pkg::data_t cmd_wdata,
   input  logic               cmd_pop
);
   import avl_bus_pkg::*;
   import tg_cfg_pkg::*;

   // entry storage, one write flag, address and data per slot
   logic  ent_write [FIFO_DEPTH];
   addr_t ent_addr  [FIFO_DEPTH];
   data_t ent_wdata [FIFO_DEPTH];

   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count;

   logic push;
   logic pop;

   // full and empty come from the registered count only
   assign ready     = (count != FIFO_CNT_W'(FIFO_DEPTH));
   assign cmd_valid = (count != '0);

   // a request is taken whenever there is room
   assign push = (write_req | read_req) & ready;
   assign pop  = cmd_pop & cmd_valid;

   // pointers and count
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leave the count unchanged
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // entry write, write_req low means a read command
   always_ff @(posedge clk) begin
      if (push) begin
         ent_write[wr_ptr] <= write_req;
         ent_addr[wr_ptr]  <= addr;
         ent_wdata[wr_ptr] <= wdata;
      end
   end

   // head entry
   assign cmd_write = ent_write[rd_ptr];
   assign cmd_addr  = ent_addr[rd_ptr];
   assign cmd_wdata = ent_wdata[rd_ptr];

endmodule

// ==== mem_model.sv ====
//////////////////////////////////////////////////
// behavioural memory standing in for the calibrated controller: pops one
// command per unstalled cycle, returns reads after a fixed latency and can
// corrupt the read data of one address
//////////////////////////////////////////////////
module mem_model (
   input  logic               clk,
   input  logic               reset_n,

   // command side, from the FIFO head
   input  logic               cmd_valid,
   input  logic               cmd_write,
   input  avl_bus_pkg::addr_t cmd_addr,
   input  avl_bus_pkg::data_t cmd_wdata,
   output logic               cmd_pop,

   // test controls
   input  logic               stall,
   input  logic               fault_en,
   input  avl_bus_pkg::addr_t fault_addr,
   input  avl_bus_pkg::data_t fault_mask,

   // read return
   output logic               rdata_valid,
   output avl_bus_pkg::data_t rdata
);
   import avl_bus_pkg::*;

   // word storage
   data_t mem [2**ADDR_W];

   // read pipeline, stage 0 is loaded at the pop edge
   logic  rd_valid_q [MEM_READ_LATENCY];
   addr_t rd_addr_q  [MEM_READ_LATENCY];
   data_t rd_data_q  [MEM_READ_LATENCY];

   logic  fault_hit;

   // stall holds back the pop, so the FIFO fills and pushes back on the driver
   assign cmd_pop = cmd_valid & ~stall;

   // writes land at the pop edge
   always_ff @(posedge clk) begin
      if (cmd_pop && cmd_write) begin
         mem[cmd_addr] <= cmd_wdata;
      end
   end

   // valid bits of the pipeline, two reads can be in flight at once
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < MEM_READ_LATENCY; i++) begin
            rd_valid_q[i] <= 1'b0;
         end
      end else begin
         rd_valid_q[0] <= cmd_pop & ~cmd_write;
         for (int i = 1; i < MEM_READ_LATENCY; i++) begin
            rd_valid_q[i] <= rd_valid_q[i-1];
         end
      end
   end

   // address and data of each read follow its valid bit
   always_ff @(posedge clk) begin
      rd_addr_q[0] <= cmd_addr;
      rd_data_q[0] <= mem[cmd_addr];
      for (int i = 1; i < MEM_READ_LATENCY; i++) begin
         rd_addr_q[i] <= rd_addr_q[i-1];
         rd_data_q[i] <= rd_data_q[i-1];
      end
   end

   //////////////////////////////////////////////////
   // fault injection on the returned beat
   //////////////////////////////////////////////////
   assign fault_hit = fault_en && (rd_addr_q[MEM_READ_LATENCY-1] == fault_addr);

   // the stored word is left intact, only the returned copy is flipped
   assign rdata_valid = rd_valid_q[MEM_READ_LATENCY-1];
   assign rdata       = rd_data_q[MEM_READ_LATENCY-1] ^ (fault_hit ? fault_mask : '0);

endmodule

// ==== tg_top.sv ====
//////////////////////////////////////////////////
// memory sanity checker top: traffic generator, command FIFO and
// memory model, with stall and fault controls brought out for test
//////////////////////////////////////////////////
module tg_top (
   input  logic                clk,
   input  logic                reset_n,

   // test controls
   input  logic                stall,
   input  logic                fault_en,
   input  avl_bus_pkg::addr_t  fault_addr,
   input  avl_bus_pkg::data_t  fault_mask,

   // status
   output logic                pass,
   output logic                fail,
   output avl_bus_pkg::data_t  pnf,
   output avl_bus_pkg::count_t words_read
);
   import avl_bus_pkg::*;

   // driver to FIFO
   logic  ready;
   logic  write_req;
   logic  read_req;
   addr_t addr;
   data_t wdata;

   // FIFO to memory
   logic  cmd_valid;
   logic  cmd_write;
   addr_t cmd_addr;
   data_t cmd_wdata;
   logic  cmd_pop;

   // memory to driver
   logic  rdata_valid;
   data_t rdata;

   tg_driver tg_driver_i (
      .clk         (clk),
      .reset_n     (reset_n),
      .ready       (ready),
      .write_req   (write_req),
      .read_req    (read_req),
      .addr        (addr),
      .wdata       (wdata),
      .rdata_valid (rdata_valid),
      .rdata       (rdata),
      .pass        (pass),
      .fail        (fail),
      .pnf         (pnf),
      .words_read  (words_read)
   );

   cmd_fifo cmd_fifo_i (
      .clk       (clk),
      .reset_n   (reset_n),
      .write_req (write_req),
      .read_req  (read_req),
      .addr      (addr),
      .wdata     (wdata),
      .ready     (ready),
      .cmd_valid (cmd_valid),
      .cmd_write (cmd_write),
      .cmd_addr  (cmd_addr),
      .cmd_wdata (cmd_wdata),
      .cmd_pop   (cmd_pop)
   );

   mem_model mem_model_i (
      .clk         (clk),
      .reset_n     (reset_n),
      .cmd_valid   (cmd_valid),
      .cmd_write   (cmd_write),
      .cmd_addr    (cmd_addr),
      .cmd_wdata   (cmd_wdata),
      .cmd_pop     (cmd_pop),
      .stall       (stall),
      .fault_en    (fault_en),
      .fault_addr  (fault_addr),
      .fault_mask  (fault_mask),
      .rdata_valid (rdata_valid),
      .rdata       (rdata)
   );

endmodule

// ==== tb_tg_top.sv ====
//////////////////////////////////////////////////
// testbench for the memory sanity checker, runs one reset-to-done
// test per line of tg_trace.txt with random stall and an optional fault
//////////////////////////////////////////////////
module tb_tg_top;
   import avl_bus_pkg::*;
   import tg_cfg_pkg::*;

   localparam int CLK_HALF       = 10;
   localparam int RESET_CYCLES   = 3;
   localparam int DONE_TIMEOUT   = 5000;
   localparam int HOLD_CYCLES    = 20;
   localparam int HOLD_STALL_PCT = 50;

   logic   clk = 1'b0;
   logic   reset_n;
   logic   stall;
   logic   fault_en;
   addr_t  fault_addr;
   data_t  fault_mask;
   logic   pass;
   logic   fail;
   data_t  pnf;
   count_t words_read;

   // percentage of cycles in which the memory refuses to pop
   int     stall_pct;

   tg_top tg_top_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .stall      (stall),
      .fault_en   (fault_en),
      .fault_addr (fault_addr),
      .fault_mask (fault_mask),
      .pass       (pass),
      .fail       (fail),
      .pnf        (pnf),
      .words_read (words_read)
   );

   always #CLK_HALF clk = ~clk;

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   // advance to the next falling edge and draw a fresh stall value there
   task automatic next_cycle();
      @(negedge clk);
      stall = (int'($urandom % 100) < stall_pct);
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("MISMATCH at time %0t: %s, got %0h, expected %0h",
                  $time, what, actual, expected);
         $display("Regression failed");
         $fatal(1, "stopping on the first error");
      end
   endtask

   // any failure that is not a wrong value, e.g. a timeout or a bad trace
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Regression failed");
      $fatal(1, "stopping on the first error");
   endtask

   // one test: reset, wait for pass or fail, check status, then watch it hold
   task automatic run_case(input int pct, input logic f_en, input addr_t f_addr,
                           input data_t f_mask, input int line_no);
      logic  exp_pass;
      int    exp_words;
      data_t exp_pnf;
      logic  done;
      int    cycles;
      int    i;
      // a fault only bites inside the test region and with a nonzero mask
      exp_pass = !(f_en && (int'(f_addr) < NUM_TEST_WORDS) && (f_mask != '0));
      exp_words = exp_pass ? NUM_TEST_WORDS : int'(f_addr) + 1;
      exp_pnf   = exp_pass ? '1 : ~f_mask;

      // controls settle while reset is low, stall keeps drawing every cycle
      reset_n    = 1'b0;
      fault_en   = f_en;
      fault_addr = f_addr;
      fault_mask = f_mask;
      stall_pct  = pct;
      for (i = 0; i < RESET_CYCLES; i++) begin
         next_cycle();
      end
      reset_n = 1'b1;

      // one rising edge out of reset, status must still show the reset values
      next_cycle();
      check_value(32'(pass), 32'(0), "pass right after reset");
      check_value(32'(fail), 32'(0), "fail right after reset");
      check_value(pnf, '1, "pnf right after reset");
      check_value(32'(words_read), 32'(0), "words_read right after reset");

      done   = 1'b0;
      cycles = 0;
      while (!done) begin
         next_cycle();
         cycles++;
         done = pass | fail;
         if (!done && cycles >= DONE_TIMEOUT) begin
            abort_run($sformatf("timeout: trace line %0d never reached pass or fail",
                                line_no));
         end
      end

      check_value(32'(pass), 32'(exp_pass), "pass at the end of the test");
      check_value(32'(fail), 32'(!exp_pass), "fail at the end of the test");
      check_value(pnf, exp_pnf, "pnf at the end of the test");
      check_value(32'(words_read), 32'(exp_words), "words_read at the end of the test");

      // the end state is sticky whatever the memory does
      stall_pct = HOLD_STALL_PCT;
      for (i = 0; i < HOLD_CYCLES; i++) begin
         next_cycle();
         check_value(32'(pass), 32'(exp_pass), "pass holding after the end");
         check_value(32'(fail), 32'(!exp_pass), "fail holding after the end");
      end
   endtask

   //////////////////////////////////////////////////
   // trace walk
   //////////////////////////////////////////////////
   initial begin
      int    fd;
      string line;
      int    n;
      int    line_no;
      int    num_cases;
      int    pct;
      int    f_en;
      int    f_addr;
      data_t f_mask;
      int    trace_pass;
      int    trace_words;
      reset_n    = 1'b0;
      stall      = 1'b0;
      fault_en   = 1'b0;
      fault_addr = '0;
      fault_mask = '0;
      stall_pct  = 0;
      line_no    = 0;
      num_cases  = 0;
      void'($urandom(56));

      fd = $fopen("tg_trace.txt", "r");
      if (fd == 0) begin
         abort_run("could not open the trace file tg_trace.txt");
      end

      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         line_no++;
         n = $sscanf(line, "%d %d %d %h %d %d",
                     pct, f_en, f_addr, f_mask, trace_pass, trace_words);
         // comment and blank lines give no fields at all
         if (n == 6) begin
            // the trace must agree with the fault rule before the DUT is judged
            if ((trace_pass != 0) != !((f_en != 0) && (f_addr < NUM_TEST_WORDS) &&
                                        (f_mask != '0))) begin
               abort_run($sformatf("trace line %0d has a pass flag that contradicts its fault",
                                   line_no));
            end
            run_case(pct, f_en != 0, addr_t'(f_addr), f_mask, line_no);
            check_value(32'(words_read), 32'(trace_words), "words_read against the trace");
            num_cases++;
         end else if (n > 0) begin
            abort_run($sformatf("trace line %0d has %0d fields instead of 6", line_no, n));
         end
      end
      $fclose(fd);

      if (num_cases == 0) begin
         $display("the trace file holds no test case");
         $display("Regression failed");
         $fatal(1, "empty trace");
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

// ==== tg_trace.txt ====
# stall_pct fault_en fault_addr(decimal) fault_mask(hex) exp_pass exp_words_read
# one reset-to-done test per line, stall_pct is the percentage of stalled cycles
0  0 0  00000000 1 16
50 0 0  00000000 1 16
90 0 0  00000000 1 16
0  1 5  00000100 0 6
50 1 15 80000001 0 16
90 1 0  0000ffff 0 1
0  1 20 ffffffff 1 16
50 1 63 00000001 1 16

// ==== vlog.f ====
avl_bus_pkg.sv
tg_cfg_pkg.sv
tg_driver.sv
cmd_fifo.sv
mem_model.sv
tg_top.sv
tb_tg_top.sv

// ==== Makefile ====
# Verilator build and run of the memory sanity checker testbench
TOP := tb_tg_top

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: compile run clean
